//--- hdl/int_div_ctrl.sv
//----------------------------------------
// integer divider control
// idle/calc/done FSM for the iterative divide
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module int_div_ctrl (
  input  logic clk,
  input  logic reset,

  // handshake inputs
  input  logic req_val,
  input  logic resp_rdy,

  // from datapath
  input  logic counter_is_zero,

  // handshake outputs
  output logic req_rdy,
  output logic resp_val,

  // datapath enables and selects
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic cntr_mux_sel,
  output logic sign_en
);

  //----------------------------------------
  // state encoding
  //----------------------------------------

  // waiting for a request
  localparam logic [1:0] STATE_IDLE = 2'd0;
  // one quotient bit per cycle
  localparam logic [1:0] STATE_CALC = 2'd1;
  // result held until the consumer takes it
  localparam logic [1:0] STATE_DONE = 2'd2;

  logic [1:0] state_reg;
  logic [1:0] state_next;

  // transfers on this edge
  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  //----------------------------------------
  // state register
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= STATE_IDLE;
    end else begin
      state_reg <= state_next;
    end
  end

  //----------------------------------------
  // next state
  //----------------------------------------

  always_comb begin
    state_next = state_reg;
    case (state_reg)
      STATE_IDLE: begin
        if (req_go) begin
          state_next = STATE_CALC;
        end
      end
      STATE_CALC: begin
        // last iteration and state change share the edge
        if (counter_is_zero) begin
          state_next = STATE_DONE;
        end
      end
      STATE_DONE: begin
        if (resp_go) begin
          state_next = STATE_IDLE;
        end
      end
      default: begin
        // unused encoding goes back to idle
        state_next = STATE_IDLE;
      end
    endcase
  end

  //----------------------------------------
  // outputs
  //----------------------------------------

  // req_rdy comes from state alone, never from req_val
  always_comb begin
    req_rdy      = 1'b0;
    resp_val     = 1'b0;
    a_en         = 1'b0;
    b_en         = 1'b0;
    a_mux_sel    = 1'b0;
    cntr_mux_sel = 1'b0;
    sign_en      = 1'b0;
    case (state_reg)
      STATE_IDLE: begin
        req_rdy = 1'b1;
        // load operands, signs and counter on the accept edge
        a_en    = req_go;
        b_en    = req_go;
        sign_en = req_go;
      end
      STATE_CALC: begin
        // iterate path and counter decrement
        a_en         = 1'b1;
        a_mux_sel    = 1'b1;
        cntr_mux_sel = 1'b1;
      end
      STATE_DONE: begin
        // a_en low keeps the result stable under back-pressure
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/int_div_defines.svh
//----------------------------------------
// integer divider widths and codes
// shared by the divider RTL and its testbench
//----------------------------------------

`ifndef INT_DIV_DEFINES_SVH
`define INT_DIV_DEFINES_SVH

// operand and result half width
`define DIV_WIDTH 32

// one quotient bit per step
`define DIV_ITERS 32

// request function codes
`define DIV_FN_UNSIGNED 1'b0
`define DIV_FN_SIGNED   1'b1

`endif

//--- hdl/int_div_dpath.sv
//----------------------------------------
// integer divider datapath
// restoring shift-subtract with sign handling
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "int_div_defines.svh"

module int_div_dpath (
  input  logic                     clk,
  input  logic                     reset,

  // request operands
  input  logic                     req_fn,
  input  logic [`DIV_WIDTH-1:0]    req_a,
  input  logic [`DIV_WIDTH-1:0]    req_b,

  // from control
  input  logic                     a_en,
  input  logic                     b_en,
  input  logic                     a_mux_sel,
  input  logic                     cntr_mux_sel,
  input  logic                     sign_en,

  // to control
  output logic                     counter_is_zero,

  // sign corrected remainder and quotient
  output int_div_pkg::div_result_t result
);

  // operand width
  localparam int W = `DIV_WIDTH;
  // remainder/quotient register width, one guard bit on top
  localparam int AW = 2 * `DIV_WIDTH + 1;
  // step counter width
  localparam int CNTR_W = $clog2(`DIV_ITERS);
  // counter load value, counts down to zero on the last step
  localparam logic [CNTR_W-1:0] CNTR_INIT = CNTR_W'(`DIV_ITERS - 1);

  //----------------------------------------
  // operand magnitudes
  //----------------------------------------

  logic          req_signed;
  logic [W-1:0]  a_mag;
  logic [W-1:0]  b_mag;

  assign req_signed = (req_fn == `DIV_FN_SIGNED);

  // only signed requests with a set sign bit get negated
  assign a_mag = (req_signed && req_a[W-1]) ? (~req_a + 1'b1) : req_a;
  assign b_mag = (req_signed && req_b[W-1]) ? (~req_b + 1'b1) : req_b;

  //----------------------------------------
  // shift-subtract step
  //----------------------------------------

  logic [AW-1:0] a_reg;
  logic [AW-1:0] b_reg;

  logic [AW-1:0] a_init;
  logic [AW-1:0] b_init;
  logic [AW-1:0] a_shift;
  logic [AW-1:0] sub_diff;
  logic          sub_neg;
  logic [AW-1:0] a_step;
  logic [AW-1:0] a_next;

  // dividend starts in the low half
  assign a_init = {{(W + 1){1'b0}}, a_mag};

  // divisor lines up with the upper half of a_reg
  assign b_init = {1'b0, b_mag, {W{1'b0}}};

  // partial remainder moves up one place per step
  assign a_shift = a_reg << 1;

  // trial subtraction against the aligned divisor
  assign sub_diff = a_shift - b_reg;

  // guard bit set means the divisor did not fit
  assign sub_neg = sub_diff[AW-1];

  // keep the difference when it fits, else restore the shifted value
  // bit 0 of both is zero, so the quotient bit is or-ed straight in
  assign a_step = (sub_neg ? a_shift : sub_diff) | {{(AW - 1){1'b0}}, ~sub_neg};

  // load path in idle, iterate path in calc
  assign a_next = a_mux_sel ? a_step : a_init;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
    // divisor is only written on the accept edge
    if (b_en) begin
      b_reg <= b_init;
    end
  end

  //----------------------------------------
  // step counter
  //----------------------------------------

  logic [CNTR_W-1:0] counter_reg;
  logic [CNTR_W-1:0] cntr_next;

  // reload on accept, count down while iterating
  assign cntr_next = cntr_mux_sel ? (counter_reg - CNTR_W'(1)) : CNTR_INIT;

  // counter follows a_en so it stays in step with a_reg
  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= '0;
    end else if (a_en) begin
      counter_reg <= cntr_next;
    end
  end

  // high during the last iteration
  assign counter_is_zero = (counter_reg == '0);

  //----------------------------------------
  // stored request signs
  //----------------------------------------

  logic fn_reg;
  logic a_sign_reg;
  logic b_sign_reg;

  always_ff @(posedge clk) begin
    if (sign_en) begin
      fn_reg     <= req_fn;
      a_sign_reg <= req_a[W-1];
      b_sign_reg <= req_b[W-1];
    end
  end

  //----------------------------------------
  // sign correction
  //----------------------------------------

  logic          fn_signed;
  logic          quot_neg;
  logic          rem_neg;
  logic [W-1:0]  quot_mag;
  logic [W-1:0]  rem_mag;

  assign fn_signed = (fn_reg == `DIV_FN_SIGNED);

  // quotient negative when exactly one operand was negative
  assign quot_neg = fn_signed && (a_sign_reg ^ b_sign_reg);

  // remainder follows the dividend
  assign rem_neg = fn_signed && a_sign_reg;

  // after the last step quotient fills the low half
  assign quot_mag = a_reg[W-1:0];
  // and the remainder the half above it
  assign rem_mag = a_reg[2*W-1:W];

  // divide by zero falls out of the same path
  // all ones quotient, remainder equal to |a|, then the usual signs
  always_comb begin
    result.fields.quot = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
    result.fields.rem  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;
  end

endmodule

`default_nettype wire

//--- hdl/int_div_iterative.sv
//----------------------------------------
// iterative integer divide unit
// 32 cycle signed/unsigned divide with val/rdy ports
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "int_div_defines.svh"

module int_div_iterative (
  input  logic                      clk,
  input  logic                      reset,

  // request side
  input  logic                      req_fn,
  input  logic [`DIV_WIDTH-1:0]     req_a,
  input  logic [`DIV_WIDTH-1:0]     req_b,
  input  logic                      req_val,
  output logic                      req_rdy,

  // response side, remainder high and quotient low
  output logic [2*`DIV_WIDTH-1:0]   resp_result,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  //----------------------------------------
  // control to datapath
  //----------------------------------------

  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;

  // datapath to control
  logic counter_is_zero;

  // field view built in the datapath
  int_div_pkg::div_result_t result;

  //----------------------------------------
  // datapath
  //----------------------------------------

  int_div_dpath int_div_dpath_i (
    .clk             (clk),
    .reset           (reset),
    .req_fn          (req_fn),
    .req_a           (req_a),
    .req_b           (req_b),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .counter_is_zero (counter_is_zero),
    .result          (result)
  );

  //----------------------------------------
  // control
  //----------------------------------------

  // response can transfer from the 33rd edge after accept
  int_div_ctrl int_div_ctrl_i (
    .clk             (clk),
    .reset           (reset),
    .req_val         (req_val),
    .resp_rdy        (resp_rdy),
    .counter_is_zero (counter_is_zero),
    .req_rdy         (req_rdy),
    .resp_val        (resp_val),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en)
  );

  // whole word leaves on the response port
  assign resp_result = result.raw;

endmodule

`default_nettype wire

//--- hdl/int_div_pkg.sv
//----------------------------------------
// integer divider types
// response word with a whole view and a field view
//----------------------------------------

`default_nettype none

`include "int_div_defines.svh"

package int_div_pkg;

  //----------------------------------------
  // response word
  //----------------------------------------

  // raw is what leaves the unit on resp_result
  // fields splits the same bits into remainder and quotient
  // remainder sits in the upper half
  typedef union packed {
    logic [2*`DIV_WIDTH-1:0] raw;
    struct packed {
      // signed or unsigned remainder
      logic [`DIV_WIDTH-1:0] rem;
      // signed or unsigned quotient
      logic [`DIV_WIDTH-1:0] quot;
    } fields;
  } div_result_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the integer divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module int_div_tb -o int_div_sim > build.log 2>&1 \
  && ./obj_dir/int_div_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2> /dev/null; echo "FAIL"; exit 1; }

cat sim.log
grep -q "^Simulation completed successfully$" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

//--- tb.f
+incdir+hdl
hdl/int_div_pkg.sv
hdl/int_div_dpath.sv
hdl/int_div_ctrl.sv
hdl/int_div_iterative.sv
verification/int_div_tb.sv

//--- verification/int_div_tb.sv
//----------------------------------------
// integer divider testbench
// random divides checked against a model
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "int_div_defines.svh"

module int_div_tb;

  localparam int W = `DIV_WIDTH;
  // test counts, corner and zero counts match the calls below
  localparam int N_UNSIGNED = 40;
  localparam int N_CORNER = 8;
  localparam int N_SIGNED = 30;
  localparam int N_ZERO = 6;
  localparam int N_STALL = 8;
  localparam int MAX_STALL = 12;
  localparam int NUM_DIVIDES = N_UNSIGNED + N_CORNER + N_SIGNED + N_ZERO + N_STALL;
  // idle watch after a stray request, one full divide and then some
  localparam int IDLE_WATCH = `DIV_ITERS + 2;
  // accept, iterations and transfer per divide, plus stall room and idle watches
  localparam int CYCLE_LIMIT = NUM_DIVIDES * (`DIV_ITERS + 2 + MAX_STALL)
                               + (N_STALL / 2) * IDLE_WATCH + 200;
  localparam logic [W-1:0] MIN_VAL = {1'b1, {(W - 1){1'b0}}};

  logic clk;
  logic reset;
  logic req_fn;
  logic [W-1:0] req_a;
  logic [W-1:0] req_b;
  logic req_val;
  logic req_rdy;
  logic [2*W-1:0] resp_result;
  logic resp_val;
  logic resp_rdy;

  integer seed = 32'h630e;
  int error_count = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycle_count = 0;

  int_div_iterative int_div_iterative_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  //----------------------------------------
  // reference model
  //----------------------------------------

  // magnitudes, unsigned divide, then signs
  // zero divisor gives all ones and |a|
  function automatic int_div_pkg::div_result_t div_model(input logic fn,
      input logic [W-1:0] a, input logic [W-1:0] b);
    int_div_pkg::div_result_t r;
    logic is_signed;
    logic [W-1:0] a_mag;
    logic [W-1:0] b_mag;
    logic [W-1:0] q_mag;
    logic [W-1:0] r_mag;
    is_signed = (fn == `DIV_FN_SIGNED);
    a_mag = (is_signed && a[W-1]) ? -a : a;
    b_mag = (is_signed && b[W-1]) ? -b : b;
    if (b_mag == '0) begin
      q_mag = '1;
      r_mag = a_mag;
    end else begin
      q_mag = a_mag / b_mag;
      r_mag = a_mag % b_mag;
    end
    // quotient negative on differing signs, remainder follows a
    r.fields.quot = (is_signed && (a[W-1] != b[W-1])) ? -q_mag : q_mag;
    r.fields.rem = (is_signed && a[W-1]) ? -r_mag : r_mag;
    return r;
  endfunction

  //----------------------------------------
  // compare tasks
  //----------------------------------------

  task automatic check_result(input string name, input int_div_pkg::div_result_t exp,
      input int_div_pkg::div_result_t act);
    if (act.raw !== exp.raw) begin
      if (act.fields.quot !== exp.fields.quot)
        $display("error %s quot expected %h actual %h", name, exp.fields.quot, act.fields.quot);
      if (act.fields.rem !== exp.fields.rem)
        $display("error %s rem expected %h actual %h", name, exp.fields.rem, act.fields.rem);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp,
      input logic act);
    if (act !== exp) begin
      $display("error %s %s expected %b actual %b", name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp,
      input int act);
    if (act != exp) begin
      $display("error %s %s expected %0d actual %0d", name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed", name);
      tests_failed++;
    end
  endtask

  //----------------------------------------
  // one divide, starts and ends on a falling edge
  //----------------------------------------

  task automatic run_divide(input string name, input logic fn, input logic [W-1:0] a,
      input logic [W-1:0] b, input int stall, input bit pulse);
    int errors_before;
    int edges;
    int_div_pkg::div_result_t expected;
    int_div_pkg::div_result_t got;
    errors_before = error_count;
    expected = div_model(fn, a, b);
    req_fn = fn;
    req_a = a;
    req_b = b;
    req_val = 1'b1;
    resp_rdy = (stall == 0);
    while (req_rdy !== 1'b1) @(negedge clk);
    // accept edge
    @(negedge clk);
    req_val = 1'b0;
    // operands must not be sampled again
    req_a = $random(seed);
    req_b = $random(seed);
    edges = 0;
    while (resp_val !== 1'b1) begin
      check_bit(name, "req_rdy while busy", 1'b0, req_rdy);
      // stray request in the middle of calc
      req_val = pulse && (edges == 10);
      req_fn = ~fn;
      @(negedge clk);
      edges++;
    end
    req_val = 1'b0;
    // response leaves on the next edge
    check_count(name, "edges to response", `DIV_ITERS + 1, edges + 1);
    got.raw = resp_result;
    check_result(name, expected, got);
    repeat (stall) begin
      @(negedge clk);
      got.raw = resp_result;
      check_bit(name, "resp_val held", 1'b1, resp_val);
      check_bit(name, "req_rdy held", 1'b0, req_rdy);
      check_result(name, expected, got);
    end
    resp_rdy = 1'b1;
    @(negedge clk);
    check_bit(name, "resp_val after transfer", 1'b0, resp_val);
    check_bit(name, "req_rdy after transfer", 1'b1, req_rdy);
    // the stray pulse must not start a second divide
    // a latched request would drop req_rdy or answer within a divide time
    if (pulse) begin
      repeat (IDLE_WATCH) begin
        @(negedge clk);
        check_bit(name, "extra response", 1'b0, resp_val);
        check_bit(name, "req_rdy after stray request", 1'b1, req_rdy);
      end
    end
    report_test(name, errors_before);
  endtask

  //----------------------------------------
  // test sequence
  //----------------------------------------

  initial begin
    int i;
    int errors_before;
    logic [W-1:0] a;
    logic [W-1:0] b;
    reset = 1'b1;
    req_fn = `DIV_FN_UNSIGNED;
    req_a = '0;
    req_b = '0;
    req_val = 1'b0;
    resp_rdy = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    errors_before = error_count;
    check_bit("after_reset", "req_rdy", 1'b1, req_rdy);
    check_bit("after_reset", "resp_val", 1'b0, resp_val);
    report_test("after_reset", errors_before);

    // divisor shifted down so quotients vary in size
    for (i = 0; i < N_UNSIGNED; i++) begin
      a = $random(seed);
      b = $random(seed);
      b = b >> ($unsigned($random(seed)) % W);
      run_divide($sformatf("unsigned_%0d", i), `DIV_FN_UNSIGNED, a, b, 0, 1'b0);
    end

    // signed corners, overflow case included
    run_divide("signed_min_by_m1", `DIV_FN_SIGNED, MIN_VAL, '1, 0, 1'b0);
    run_divide("signed_min_by_1", `DIV_FN_SIGNED, MIN_VAL, 32'd1, 0, 1'b0);
    run_divide("signed_min_by_min", `DIV_FN_SIGNED, MIN_VAL, MIN_VAL, 0, 1'b0);
    run_divide("signed_m7_by_2", `DIV_FN_SIGNED, -32'sd7, 32'd2, 0, 1'b0);
    run_divide("signed_7_by_m2", `DIV_FN_SIGNED, 32'd7, -32'sd2, 0, 1'b0);
    run_divide("signed_m7_by_m2", `DIV_FN_SIGNED, -32'sd7, -32'sd2, 0, 1'b0);
    run_divide("signed_m1_by_min", `DIV_FN_SIGNED, '1, MIN_VAL, 0, 1'b0);
    run_divide("signed_min_by_3", `DIV_FN_SIGNED, MIN_VAL, 32'd3, 0, 1'b0);

    // arithmetic shift keeps the divisor sign
    for (i = 0; i < N_SIGNED; i++) begin
      a = $random(seed);
      b = $random(seed);
      b = $signed(b) >>> ($unsigned($random(seed)) % W);
      run_divide($sformatf("signed_%0d", i), `DIV_FN_SIGNED, a, b, 0, 1'b0);
    end

    // zero divisor in both modes
    run_divide("zero_unsigned_rand", `DIV_FN_UNSIGNED, $random(seed), '0, 0, 1'b0);
    run_divide("zero_unsigned_zero", `DIV_FN_UNSIGNED, '0, '0, 0, 1'b0);
    run_divide("zero_signed_pos", `DIV_FN_SIGNED, 32'd12345, '0, 0, 1'b0);
    run_divide("zero_signed_neg", `DIV_FN_SIGNED, -32'sd12345, '0, 0, 1'b0);
    run_divide("zero_signed_min", `DIV_FN_SIGNED, MIN_VAL, '0, 0, 1'b0);
    run_divide("zero_signed_rand", `DIV_FN_SIGNED, $random(seed), '0, 0, 1'b0);

    // back-pressure, every other one with a stray request
    for (i = 0; i < N_STALL; i++) begin
      a = $random(seed);
      b = $random(seed);
      b = b >> ($unsigned($random(seed)) % W);
      run_divide($sformatf("stall_%0d", i), i[0], a, b,
                 1 + ($unsigned($random(seed)) % MAX_STALL), (i % 2) == 0);
    end

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
